//--- src/br_pkg.sv
package br_pkg;

    localparam int XLEN   = 32;
    localparam int NUM_BR = 4;

    typedef logic [NUM_BR-1:0] br_mask_t; // One-hot id or older-branch mask

    typedef enum logic [1:0] {
        NOTHING = 2'd0,
        CLEAR   = 2'd1,
        SQUASH  = 2'd2
    } br_task_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic            pred_taken;
        br_mask_t        id;
    } br_issue_t;

    typedef struct packed {
        logic [2:0]      funct3;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_next; // Fall-through, pc + 4
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic            pred_taken;
        br_mask_t        id;
    } br_decoded_t;

    typedef struct packed {
        br_mask_t        id;
        logic [XLEN-1:0] target;
        logic            taken;
        logic            pred_correct;
    } br_result_t;

    // Resolved branch drops out of every dependency mask
    function automatic br_mask_t mask_update(input br_mask_t mask, input br_task_e tsk,
                                             input br_mask_t id);
        return (tsk == CLEAR) ? (mask & ~id) : mask;
    endfunction

    function automatic logic mask_killed(input br_mask_t mask, input br_task_e tsk,
                                         input br_mask_t id);
        return (tsk == SQUASH) && ((mask & id) != '0);
    endfunction

endpackage

//--- src/br_stage_if.sv
`timescale 1ns/1ps

// Valid/ready link between two pipeline stages. The mask travels beside the
// payload so each stage can apply CLEAR and SQUASH without knowing the struct.
interface br_stage_if
    import br_pkg::*;
#(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    br_mask_t b_mask; // Older unresolved branches
    payload_t data;

    modport source (
        output valid,
        output b_mask,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  b_mask,
        input  data,
        output ready
    );

endinterface

//--- src/br_decode.sv
`timescale 1ns/1ps

module br_decode
    import br_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       issue_valid,
    output logic       issue_ready,
    input  br_issue_t  issue,
    input  br_mask_t   issue_mask,
    input  br_task_e   br_task,
    input  br_mask_t   br_id,
    br_stage_if.source out
);

    logic        valid_q;
    br_decoded_t data_q;
    br_mask_t    mask_q;
    br_decoded_t dec_d;
    logic        accept;

    always_comb begin
        dec_d.funct3     = issue.inst[14:12];
        dec_d.imm        = {{(XLEN-13){issue.inst[31]}}, issue.inst[31], issue.inst[7],
                            issue.inst[30:25], issue.inst[11:8], 1'b0}; // B-type
        dec_d.pc         = issue.pc;
        dec_d.pc_next    = issue.pc + XLEN'(4);
        dec_d.rs1        = issue.rs1;
        dec_d.rs2        = issue.rs2;
        dec_d.pred_taken = issue.pred_taken;
        dec_d.id         = issue.id;
    end

    assign issue_ready = !valid_q || out.ready; // Empty or draining
    assign accept      = issue_valid && issue_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (issue_ready) begin
            valid_q <= issue_valid && !mask_killed(issue_mask, br_task, br_id);
        end else if (mask_killed(mask_q, br_task, br_id)) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            data_q <= dec_d;
            mask_q <= mask_update(issue_mask, br_task, br_id);
        end else begin
            mask_q <= mask_update(mask_q, br_task, br_id);
        end
    end

    // A squashed entry is withdrawn in the same cycle
    assign out.valid  = valid_q && !mask_killed(mask_q, br_task, br_id);
    assign out.b_mask = mask_q;
    assign out.data   = data_q;

endmodule

//--- src/br_execute.sv
`timescale 1ns/1ps

module br_execute
    import br_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    br_stage_if.sink   in,
    br_stage_if.source out,
    input  br_task_e   br_task,
    input  br_mask_t   br_id
);

    logic            valid_q;
    br_result_t      res_q;
    br_mask_t        mask_q;
    logic            taken;
    logic [XLEN-1:0] branch_target;
    br_result_t      res_d;
    logic            accept;

    always_comb begin
        case (in.data.funct3)
            3'b000:  taken = in.data.rs1 == in.data.rs2;                   // BEQ
            3'b001:  taken = in.data.rs1 != in.data.rs2;                   // BNE
            3'b100:  taken = $signed(in.data.rs1) <  $signed(in.data.rs2); // BLT
            3'b101:  taken = $signed(in.data.rs1) >= $signed(in.data.rs2); // BGE
            3'b110:  taken = in.data.rs1 <  in.data.rs2;                   // BLTU
            3'b111:  taken = in.data.rs1 >= in.data.rs2;                   // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign branch_target = in.data.pc + in.data.imm;

    always_comb begin
        res_d.id           = in.data.id;
        res_d.target       = taken ? branch_target : in.data.pc_next;
        res_d.taken        = taken;
        res_d.pred_correct = in.data.pred_taken == taken;
    end

    assign in.ready = !valid_q || out.ready;
    assign accept   = in.valid && in.ready; // Killed entries arrive with valid low

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in.ready) begin
            valid_q <= in.valid;
        end else if (mask_killed(mask_q, br_task, br_id)) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            res_q  <= res_d;
            mask_q <= mask_update(in.b_mask, br_task, br_id);
        end else begin
            mask_q <= mask_update(mask_q, br_task, br_id);
        end
    end

    // Keeps a younger branch out of the result stage during its squash
    assign out.valid  = valid_q && !mask_killed(mask_q, br_task, br_id);
    assign out.b_mask = mask_q;
    assign out.data   = res_q;

endmodule

//--- src/br_result.sv
`timescale 1ns/1ps

module br_result
    import br_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    br_stage_if.sink   in,
    output logic       res_valid,
    input  logic       res_ready,
    output br_result_t res,
    output br_task_e   br_task,
    output br_mask_t   br_id
);

    logic       valid_q;
    br_result_t res_q;
    logic       load;

    assign in.ready = !valid_q || res_ready;
    assign load     = in.valid && in.ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in.ready) begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            res_q <= in.data;
        end
    end

    // One pulse per branch, issued on load and never repeated while stalled
    always_ff @(posedge clock) begin
        if (rst) begin
            br_task <= NOTHING;
            br_id   <= '0;
        end else if (load) begin
            br_task <= in.data.pred_correct ? CLEAR : SQUASH;
            br_id   <= in.data.id;
        end else begin
            br_task <= NOTHING;
            br_id   <= '0;
        end
    end

    assign res_valid = valid_q;
    assign res       = res_q;

endmodule

//--- src/br_unit_top.sv
`timescale 1ns/1ps

module br_unit_top
    import br_pkg::*;
(
    input  logic            clock,
    input  logic            rst,
    input  logic            issue_valid,
    output logic            issue_ready,
    input  logic [XLEN-1:0] issue_pc,
    input  logic [31:0]     issue_inst,
    input  logic [XLEN-1:0] issue_rs1,
    input  logic [XLEN-1:0] issue_rs2,
    input  logic            issue_pred_taken,
    input  br_mask_t        issue_id,
    input  br_mask_t        issue_mask,
    output logic            res_valid,
    input  logic            res_ready,
    output br_mask_t        res_id,
    output logic [XLEN-1:0] res_target,
    output logic            res_taken,
    output logic            res_pred_correct,
    output br_task_e        br_task,
    output br_mask_t        br_id
);

    br_issue_t  issue;
    br_result_t res;

    br_stage_if #(.payload_t(br_decoded_t)) dec_to_ex ();
    br_stage_if #(.payload_t(br_result_t))  ex_to_res ();

    assign issue = '{pc: issue_pc, inst: issue_inst, rs1: issue_rs1, rs2: issue_rs2,
                     pred_taken: issue_pred_taken, id: issue_id};

    br_decode u_br_decode (
        .clock       (clock),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .issue_mask  (issue_mask),
        .br_task     (br_task),
        .br_id       (br_id),
        .out         (dec_to_ex.source)
    );

    br_execute u_br_execute (
        .clock   (clock),
        .rst     (rst),
        .in      (dec_to_ex.sink),
        .out     (ex_to_res.source),
        .br_task (br_task),
        .br_id   (br_id)
    );

    br_result u_br_result (
        .clock     (clock),
        .rst       (rst),
        .in        (ex_to_res.sink),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .br_task   (br_task),
        .br_id     (br_id)
    );

    assign res_id           = res.id;
    assign res_target       = res.target;
    assign res_taken        = res.taken;
    assign res_pred_correct = res.pred_correct;

endmodule

//--- test/br_unit_checker.sv
`timescale 1ns/1ps

module br_unit_checker
    import br_pkg::*;
(
    input logic            clock,
    input logic            rst,
    input logic            issue_ready,
    input logic            res_valid,
    input logic            res_ready,
    input br_mask_t        res_id,
    input logic [XLEN-1:0] res_target,
    input logic            res_taken,
    input logic            res_pred_correct,
    input br_task_e        br_task,
    input br_mask_t        br_id
);

    int fail_count = 0; // Read by the testbench at the end of the run

    // A stalled result must stay put until the sink takes it
    property result_held;
        @(posedge clock) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_id) && $stable(res_target)
                                    && $stable(res_taken) && $stable(res_pred_correct);
    endproperty

    property broadcast_one_hot;
        @(posedge clock) disable iff (rst)
        br_task == NOTHING || $onehot(br_id);
    endproperty

    property reset_state;
        @(posedge clock) $fell(rst) |-> issue_ready && !res_valid;
    endproperty

    result_held_a: assert property (result_held) else begin
        fail_count++;
        $error("result fields changed while res_ready was low");
    end

    broadcast_one_hot_a: assert property (broadcast_one_hot) else begin
        fail_count++;
        $error("broadcast id is not one-hot");
    end

    reset_state_a: assert property (reset_state) else begin
        fail_count++;
        $error("pipeline not empty in the first cycle after reset");
    end

endmodule

bind br_unit_top br_unit_checker u_br_unit_checker (
    .clock            (clock),
    .rst              (rst),
    .issue_ready      (issue_ready),
    .res_valid        (res_valid),
    .res_ready        (res_ready),
    .res_id           (res_id),
    .res_target       (res_target),
    .res_taken        (res_taken),
    .res_pred_correct (res_pred_correct),
    .br_task          (br_task),
    .br_id            (br_id)
);

//--- test/br_unit_tb.sv
`timescale 1ns/1ps

module br_unit_tb
    import br_pkg::*;
();

    localparam int MAX_CYCLES = 4000; // Longest run is a few hundred cycles

    typedef struct packed {
        br_mask_t        id;
        br_mask_t        mask;
        logic [XLEN-1:0] target;
        logic            taken;
        logic            pred_correct;
        logic            bcast_seen;
    } exp_t;

    logic            clock;
    logic            rst;
    logic            issue_valid;
    logic            issue_ready;
    logic [XLEN-1:0] issue_pc;
    logic [31:0]     issue_inst;
    logic [XLEN-1:0] issue_rs1;
    logic [XLEN-1:0] issue_rs2;
    logic            issue_pred_taken;
    br_mask_t        issue_id;
    br_mask_t        issue_mask;
    logic            res_valid;
    logic            res_ready;
    br_mask_t        res_id;
    logic [XLEN-1:0] res_target;
    logic            res_taken;
    logic            res_pred_correct;
    br_task_e        br_task;
    br_mask_t        br_id;

    exp_t exp_q[$];
    exp_t cur_exp; // Expected outcome of the branch on the issue port
    int   errors;
    int   checks;
    int   cycles;
    int   bcast_count;
    int   resolved_count;
    int   drop_count;
    int   next_slot;
    int   stretch;
    logic stall_mode;

    br_unit_top u_br_unit_top (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic require(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("At %0t: %s", $time, what);
            errors++;
        end
    endtask

    // Signed order taken as unsigned order of the sign-flipped values
    function automatic logic branch_taken(input logic [2:0] funct3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic [31:0] sa;
        logic [31:0] sb;
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        case (funct3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return sa < sb;
            3'b101:  return !(sa < sb);
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] encode_branch(input logic [2:0] funct3,
                                                  input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [12:0] random_imm();
        return 13'($urandom) & 13'h1ffe;
    endfunction

    task automatic issue_branch(input logic [2:0] funct3, input logic [31:0] a,
                                input logic [31:0] b, input logic [12:0] imm,
                                input logic pred, input br_mask_t mask, output br_mask_t id);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] offset;
        logic            taken;
        pc        = $urandom & 32'hffff_fffc;
        offset    = {{(XLEN-13){imm[12]}}, imm};
        taken     = branch_taken(funct3, a, b);
        id        = br_mask_t'(1) << next_slot; // Ids rotate through all slots
        next_slot = (next_slot + 1) % NUM_BR;
        @(negedge clock);
        issue_valid      = 1'b1;
        issue_pc         = pc;
        issue_inst       = encode_branch(funct3, imm);
        issue_rs1        = a;
        issue_rs2        = b;
        issue_pred_taken = pred;
        issue_id         = id;
        issue_mask       = mask;
        cur_exp = '{id: id, mask: mask, target: taken ? pc + offset : pc + 32'd4,
                    taken: taken, pred_correct: pred == taken, bcast_seen: 1'b0};
        do @(posedge clock); while (!issue_ready);
    endtask

    task automatic idle();
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clock);
        repeat (3) @(negedge clock);
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("%-14s %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAILED",
                 errors - errs_before);
    endtask

    // Reference queue follows handshakes and broadcasts at every edge
    always @(posedge clock) begin
        exp_t     head;
        exp_t     kept[$];
        br_task_e exp_task;
        if (!rst) begin
            if (br_task != NOTHING) begin
                bcast_count++;
                if (exp_q.size() == 0) begin
                    require(1'b0, "broadcast seen with no branch expected");
                end else begin
                    exp_task = exp_q[0].pred_correct ? CLEAR : SQUASH;
                    compare_value("br_id", 32'(exp_q[0].id), 32'(br_id));
                    compare_value("br_task", 32'(exp_task), 32'(br_task));
                    require(!exp_q[0].bcast_seen, "second broadcast for one branch");
                    require(res_valid, "broadcast without a valid result");
                    exp_q[0].bcast_seen = 1'b1;
                end
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    require(1'b0, "result arrived with no branch expected");
                end else begin
                    head = exp_q.pop_front();
                    compare_value("res_id", 32'(head.id), 32'(res_id));
                    compare_value("res_target", head.target, res_target);
                    compare_value("res_taken", 32'(head.taken), 32'(res_taken));
                    compare_value("res_pred_correct", 32'(head.pred_correct),
                                  32'(res_pred_correct));
                    require(head.bcast_seen, "result left without its broadcast");
                    resolved_count++;
                end
            end
            if (issue_valid && issue_ready) exp_q.push_back(cur_exp);
            if (br_task == CLEAR) begin
                foreach (exp_q[i]) exp_q[i].mask = exp_q[i].mask & ~br_id;
            end else if (br_task == SQUASH) begin
                kept.delete();
                foreach (exp_q[i]) begin
                    if ((exp_q[i].mask & br_id) == '0) kept.push_back(exp_q[i]);
                    else drop_count++;
                end
                exp_q = kept;
            end
        end
    end

    // Random stall stretches on the result side
    always @(negedge clock) begin
        if (!stall_mode) begin
            res_ready = 1'b1;
        end else if (stretch == 0) begin
            res_ready = !res_ready;
            stretch   = $urandom_range(1, 6);
        end else begin
            stretch--;
        end
    end

    initial begin
        br_mask_t    id_a;
        br_mask_t    id_b;
        br_mask_t    id_c;
        br_mask_t    id_d;
        logic [31:0] a;
        logic [31:0] b;
        int          start;
        void'($urandom(32'hf8cedda0));
        clock = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_pc = '0;
        issue_inst = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_pred_taken = 1'b0;
        issue_id = '0;
        issue_mask = '0;
        res_ready = 1'b1;
        stall_mode = 1'b0;
        cur_exp = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        bcast_count = 0;
        resolved_count = 0;
        drop_count = 0;
        next_slot = 0;
        stretch = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        start = errors;
        @(posedge clock);
        compare_value("res_valid", 32'd0, 32'(res_valid));
        compare_value("br_task", 32'(NOTHING), 32'(br_task));
        compare_value("issue_ready", 32'd1, 32'(issue_ready));
        end_test("reset_state", start);

        start = errors;
        for (int c = 0; c < 8; c++) begin
            if (c != 3) begin
                for (int k = 0; k < 10; k++) begin
                    case (k)
                        0: begin a = 32'd5; b = 32'd5; end
                        1: begin a = 32'h7fff_ffff; b = 32'h8000_0000; end
                        2: begin a = 32'h8000_0000; b = 32'h7fff_ffff; end
                        3: begin a = '1; b = '0; end
                        4: begin a = '0; b = '1; end
                        default: begin a = $urandom; b = (k % 2 == 1) ? a : $urandom; end
                    endcase
                    issue_branch(3'(c), a, b, random_imm(), 1'($urandom), '0, id_a);
                end
            end
        end
        idle();
        drain();
        end_test("compare_rules", start);

        start = errors;
        bcast_count = 0;
        resolved_count = 0;
        for (int k = 0; k < 8; k++) begin
            issue_branch(3'b000, 32'd3, (k < 4) ? 32'd3 : 32'd4, random_imm(), 1'(k % 2),
                         '0, id_a);
        end
        idle();
        drain();
        compare_value("broadcasts", 32'd8, bcast_count);
        compare_value("resolved", 32'd8, resolved_count);
        end_test("broadcast", start);

        start = errors;
        drop_count = 0;
        issue_branch(3'b000, 32'd7, 32'd7, random_imm(), 1'b0, '0, id_a); // Mispredicted
        issue_branch(3'b001, 32'd1, 32'd2, random_imm(), 1'b1, id_a, id_b);
        issue_branch(3'b110, 32'd1, 32'd2, random_imm(), 1'b1, '0, id_d);
        issue_branch(3'b100, 32'd3, 32'd2, random_imm(), 1'b0, id_a | id_b, id_c);
        idle();
        drain();
        compare_value("squashed branches", 32'd2, drop_count);
        end_test("squash", start);

        start = errors;
        drop_count = 0;
        issue_branch(3'b000, 32'd4, 32'd4, random_imm(), 1'b1, '0, id_a);   // CLEAR
        issue_branch(3'b001, 32'd4, 32'd4, random_imm(), 1'b1, id_a, id_b); // SQUASH
        issue_branch(3'b000, 32'd0, 32'd0, random_imm(), 1'b1, id_a | id_b, id_c);
        issue_branch(3'b101, 32'd9, 32'd2, random_imm(), 1'b1, id_a, id_d);
        idle();
        drain();
        compare_value("squashed branches", 32'd1, drop_count);
        end_test("mask_clear", start);

        start = errors;
        stall_mode = 1'b1;
        for (int k = 0; k < 40; k++) begin
            issue_branch(3'($urandom), $urandom, $urandom, random_imm(), 1'($urandom),
                         '0, id_a);
        end
        idle();
        drain();
        stall_mode = 1'b0;
        end_test("back_pressure", start);

        errors = errors + u_br_unit_top.u_br_unit_checker.fail_count;
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/br_pkg.sv
src/br_stage_if.sv
src/br_decode.sv
src/br_execute.sv
src/br_result.sv
src/br_unit_top.sv
test/br_unit_checker.sv
test/br_unit_tb.sv

//--- Bender.yml
package:
  name: br_unit

sources:
  - files:
      - src/br_pkg.sv
      - src/br_stage_if.sv
      - src/br_decode.sv
      - src/br_execute.sv
      - src/br_result.sv
      - src/br_unit_top.sv
  - target: test
    files:
      - test/br_unit_checker.sv
      - test/br_unit_tb.sv
